//--- Makefile
# Verilator build and run of the dts testbench

VERILATOR ?= verilator
TOP       ?= dts_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(wildcard hdl/*.sv testbench/*.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	@./$(SIM) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
hdl/dts_pkg.sv
hdl/dts_word_if.sv
hdl/dts_deformat.sv
hdl/dts_build_samples.sv
hdl/dts_sample_fifo.sv
hdl/dts_host_port.sv
hdl/dts_top.sv
testbench/dts_tb_checker.sv
testbench/dts_tb.sv

//--- hdl/dts_build_samples.sv
`timescale 1ns/1ps
`default_nettype none

// turns a lane-word triplet into one sample word, 3-bit or 8-bit-as-12
module dts_build_samples (
  input  logic                              three_bit,
  input  logic [3*dts_pkg::lane_width-1:0]  triplet,  // top | middle | bottom
  output dts_pkg::sample_word_t             samples   // earliest sample in MSBs
);

  localparam int lw = dts_pkg::lane_width;

  logic [lw-1:0] top_w;
  logic [lw-1:0] mid_w;
  logic [lw-1:0] bot_w;

  assign top_w = triplet[3*lw-1:2*lw];
  assign mid_w = triplet[2*lw-1:lw];
  assign bot_w = triplet[lw-1:0];

  always_comb begin
    samples = '0;
    if (three_bit) begin
      // bit i of each lane -> 3-bit field i, top lane as MSB
      for (int i = 0; i < dts_pkg::n_samples_3; i++) begin
        samples.s3[i] = {top_w[i], mid_w[i], bot_w[i]};
      end
    end else begin
      // byte i of top -> field 2i, byte i of bottom -> field 2i+1
      // middle lane carries nothing in this mode
      for (int i = 0; i < dts_pkg::n_samples_12 / 2; i++) begin
        samples.s12[2*i]   = {top_w[8*i +: 8], 4'b0000};  // widened by left shift
        samples.s12[2*i+1] = {bot_w[8*i +: 8], 4'b0000};
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dts_deformat.sv
`timescale 1ns/1ps
`default_nettype none

// gathers 32-bit lane beats into 128-bit lane words, three lanes at a time
module dts_deformat (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [3*dts_pkg::beat_width-1:0]  lane_beat,     // top | middle | bottom
  input  logic                              beat_valid,
  input  logic                              frame_start,   // first beat of a word
  input  logic                              is_three_bit,  // mode, sampled with frame_start
  output logic [3*dts_pkg::lane_width-1:0]  triplet,       // top | middle | bottom words
  output logic                              word_three_bit,
  output logic                              word_valid,    // one-cycle pulse per word
  output logic                              align_error    // sticky
);

  localparam int cnt_w = $clog2(dts_pkg::beats_per_word);
  localparam logic [cnt_w-1:0] last_beat = cnt_w'(dts_pkg::beats_per_word - 1);

  logic [2:0][dts_pkg::beat_width-1:0] beat;     // [2] top .. [0] bottom
  logic [2:0][dts_pkg::lane_width-1:0] lane_sr;  // one shift reg per lane
  logic [cnt_w-1:0]                    beat_cnt; // beats held of current word
  logic                                gathering;
  logic                                take_beat;

  assign beat      = lane_beat;
  assign gathering = (beat_cnt != '0);  // partial word in progress
  assign take_beat = beat_valid && (frame_start || gathering);

  // lane words are complete in the shift regs while word_valid is high
  assign triplet = lane_sr;

  // new beat enters at the top, so beat 0 ends up in bits 31:0
  always_ff @(posedge clk) begin
    if (take_beat) begin
      for (int l = 0; l < 3; l++) begin
        lane_sr[l] <= {beat[l], lane_sr[l][dts_pkg::lane_width-1:dts_pkg::beat_width]};
      end
    end
  end

  // beat counting, mode latch, word pulse and realignment
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      beat_cnt       <= '0;
      word_three_bit <= 1'b0;
      word_valid     <= 1'b0;
      align_error    <= 1'b0;
    end else begin
      word_valid <= 1'b0;  // pulse by default low
      if (beat_valid) begin
        if (frame_start) begin
          // frame start mid-word: drop the partial, restart on this beat
          if (gathering) begin
            align_error <= 1'b1;
          end
          word_three_bit <= is_three_bit;  // held for the whole word
          beat_cnt       <= cnt_w'(1);
        end else if (gathering) begin
          if (beat_cnt == last_beat) begin
            beat_cnt   <= '0;    // back to idle
            word_valid <= 1'b1;  // word visible next cycle
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        // idle beat without frame_start is ignored
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dts_host_port.sv
`timescale 1ns/1ps
`default_nettype none

// four-phase req/ack output, one sample word per handshake
module dts_host_port (
  input  logic                  clk,
  input  logic                  arst_n,
  dts_word_if.port_side         rd,
  output dts_pkg::sample_word_t out_data,
  output logic                  out_three_bit,
  output logic                  out_req,
  input  logic                  out_ack
);

  // FSM encoding
  localparam logic [1:0] st_idle = 2'd0;  // waiting for a word
  localparam logic [1:0] st_req  = 2'd1;  // req high, waiting for ack
  localparam logic [1:0] st_rel  = 2'd2;  // req low, waiting for ack to drop

  logic [1:0]           state;
  dts_pkg::fifo_entry_t hold;  // popped entry, stable for the handshake

  // take the head only when idle, so ack is already low
  assign rd.pop = (state == st_idle) && rd.valid;

  assign out_req       = (state == st_req);
  assign out_data      = hold.word;
  assign out_three_bit = hold.three_bit;

  always_ff @(posedge clk) begin
    if (rd.pop) begin
      hold <= rd.entry;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (rd.valid) begin
            state <= st_req;  // req rises next cycle
          end
        end
        st_req: begin
          if (out_ack) begin
            state <= st_rel;  // drop req
          end
        end
        st_rel: begin
          if (!out_ack) begin
            state <= st_idle;  // transfer done on ack fall
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/dts_pkg.sv
`default_nettype none

// shared constants and word types for the ADC data transport receive path
package dts_pkg;

  // lane geometry
  localparam int lane_width     = 128;  // bits per lane word
  localparam int beat_width     = 32;   // bits per lane per beat
  localparam int beats_per_word = lane_width / beat_width;  // 4 beats

  // sample field counts
  localparam int n_samples_3  = lane_width;          // one 3-bit sample per lane bit
  localparam int n_samples_12 = 2 * lane_width / 8;  // top and bottom bytes, alternating

  // one 384-bit output word, seen either as 3-bit or as 12-bit fields
  // index 0 is the MSB field, i.e. the earliest sample
  typedef union packed {
    logic [0:n_samples_3-1][2:0]   s3;   // {top, middle, bottom} per field
    logic [0:n_samples_12-1][11:0] s12;  // {byte, 4'b0} per field
  } sample_word_t;

  // buffered word plus the mode it was built in
  typedef struct packed {
    sample_word_t word;
    logic         three_bit;  // 1 = 3-bit samples, 0 = 8-bit as 12
  } fifo_entry_t;

endpackage

`default_nettype wire

//--- hdl/dts_sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// circular buffer of built sample words, drops on full
module dts_sample_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  wr_en,     // word_valid pulse
  input  dts_pkg::fifo_entry_t  wr_entry,
  dts_word_if.fifo_side         rd,
  output logic                  overflow   // sticky until reset
);

  localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cnt_w = $clog2(DEPTH + 1);
  localparam logic [ptr_w-1:0] last_slot = ptr_w'(DEPTH - 1);

  dts_pkg::fifo_entry_t mem [DEPTH];  // payload, no reset
  logic [ptr_w-1:0]     wr_ptr;
  logic [ptr_w-1:0]     rd_ptr;
  logic [cnt_w-1:0]     count;
  logic                 full;
  logic                 empty;
  logic                 do_wr;
  logic                 do_rd;

  assign full  = (count == cnt_w'(DEPTH));
  assign empty = (count == '0);
  assign do_wr = wr_en && !full;     // no back-pressure, so a full write is lost
  assign do_rd = rd.pop && !empty;

  // head always presented
  assign rd.entry = mem[rd_ptr];
  assign rd.valid = !empty;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  // pointers, occupancy and drop flag
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;  // wrap for any depth
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
      if (wr_en && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dts_top.sv
`timescale 1ns/1ps
`default_nettype none

// receive chain: deformat -> build samples -> FIFO -> host port
module dts_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [3*dts_pkg::beat_width-1:0]  lane_beat,   // top in MSBs
  input  logic                              beat_valid,
  input  logic                              frame_start,
  input  logic                              is_three_bit,
  input  logic                              out_ack,
  output logic [3*dts_pkg::lane_width-1:0]  out_data,
  output logic                              out_three_bit,
  output logic                              out_req,
  output logic                              overflow,
  output logic                              align_error
);

  logic [3*dts_pkg::lane_width-1:0] triplet;
  logic                             word_three_bit;
  logic                             word_valid;
  dts_pkg::sample_word_t            samples;
  dts_pkg::fifo_entry_t             wr_entry;
  dts_pkg::sample_word_t            port_data;

  dts_word_if word_if ();  // FIFO head to host port

  dts_deformat deformat_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .lane_beat      (lane_beat),
    .beat_valid     (beat_valid),
    .frame_start    (frame_start),
    .is_three_bit   (is_three_bit),
    .triplet        (triplet),
    .word_three_bit (word_three_bit),
    .word_valid     (word_valid),
    .align_error    (align_error)
  );

  // combinational, so build and FIFO write share the word_valid cycle
  dts_build_samples build_i (
    .three_bit (word_three_bit),
    .triplet   (triplet),
    .samples   (samples)
  );

  assign wr_entry.word      = samples;
  assign wr_entry.three_bit = word_three_bit;  // mode travels with the word

  dts_sample_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) fifo_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_en    (word_valid),
    .wr_entry (wr_entry),
    .rd       (word_if.fifo_side),
    .overflow (overflow)
  );

  dts_host_port port_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .rd            (word_if.port_side),
    .out_data      (port_data),
    .out_three_bit (out_three_bit),
    .out_req       (out_req),
    .out_ack       (out_ack)
  );

  assign out_data = port_data;  // union flattened to plain bits at the boundary

endmodule

`default_nettype wire

//--- hdl/dts_word_if.sv
`timescale 1ns/1ps
`default_nettype none

// link between the sample FIFO head and the host port
interface dts_word_if;

  dts_pkg::fifo_entry_t entry;  // head of FIFO
  logic                 valid;  // FIFO not empty
  logic                 pop;    // one-cycle take of the head

  // FIFO presents the head, takes pop
  modport fifo_side (
    output entry,
    output valid,
    input  pop
  );

  // host port consumes the head
  modport port_side (
    input  entry,
    input  valid,
    output pop
  );

endinterface

`default_nettype wire

//--- testbench/dts_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dts_tb;

  localparam int lw          = dts_pkg::lane_width;
  localparam int bw          = dts_pkg::beat_width;
  localparam int drive_delay = 2;     // ns after the rising edge
  localparam int max_cycles  = 2000;  // far above the length of the full run

  logic            clk;
  logic            arst_n;
  logic [3*bw-1:0] lane_beat;
  logic            beat_valid;
  logic            frame_start;
  logic            is_three_bit;
  logic            out_ack;
  logic [3*lw-1:0] out_data;
  logic            out_three_bit;
  logic            out_req;
  logic            overflow;
  logic            align_error;

  int errors;       // over the whole run
  int test_errors;  // within the current test
  int tests_run;
  int cycle_count;

  dts_top #(
    .FIFO_DEPTH (4)
  ) dts_top_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .lane_beat     (lane_beat),
    .beat_valid    (beat_valid),
    .frame_start   (frame_start),
    .is_three_bit  (is_three_bit),
    .out_ack       (out_ack),
    .out_data      (out_data),
    .out_three_bit (out_three_bit),
    .out_req       (out_req),
    .overflow      (overflow),
    .align_error   (align_error)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // one cycle step; outputs are settled and inputs may change here
  task automatic tick();
    @(posedge clk);
    #drive_delay;
  endtask

  function automatic logic [lw-1:0] rand_lane();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // expected sample word from the lane words, by the format rules
  function automatic dts_pkg::sample_word_t expected_word(input logic three_bit,
      input logic [lw-1:0] top, input logic [lw-1:0] mid, input logic [lw-1:0] bot);
    dts_pkg::sample_word_t w;
    w = '0;
    if (three_bit) begin
      for (int i = 0; i < lw; i++) begin
        w.s3[i] = {top[i], mid[i], bot[i]};  // top lane is the field MSB
      end
    end else begin
      for (int i = 0; i < lw / 8; i++) begin
        w.s12[2*i]   = {top[8*i +: 8], 4'h0};
        w.s12[2*i+1] = {bot[8*i +: 8], 4'h0};  // middle lane dropped
      end
    end
    return w;
  endfunction

  task automatic compare_word(input string name, input dts_pkg::sample_word_t got,
      input dts_pkg::sample_word_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      test_errors++;
    end
  endtask

  // n beats of one word, frame_start on the first
  task automatic send_beats(input logic [lw-1:0] top, input logic [lw-1:0] mid,
      input logic [lw-1:0] bot, input logic three_bit, input int n);
    for (int b = 0; b < n; b++) begin
      lane_beat    = {top[bw*b +: bw], mid[bw*b +: bw], bot[bw*b +: bw]};
      beat_valid   = 1'b1;
      frame_start  = (b == 0);
      is_three_bit = three_bit;
      tick();
    end
    beat_valid  = 1'b0;
    frame_start = 1'b0;
  endtask

  // one full four-phase handshake from the host side
  task automatic host_take(input int ack_delay, output dts_pkg::sample_word_t word,
      output logic three_bit);
    while (!out_req) tick();  // watchdog covers a missing req
    word      = out_data;
    three_bit = out_three_bit;
    repeat (ack_delay) tick();
    out_ack = 1'b1;
    while (out_req) tick();
    tick();  // host lingers on ack, req must stay low meanwhile
    out_ack = 1'b0;
    tick();
  endtask

  // no word may show up for n cycles
  task automatic expect_quiet(input int n);
    repeat (n) begin
      tick();
      if (out_req) begin
        $display("unexpected word offered on out_req at %0t ns", $time);
        test_errors++;
        break;
      end
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    errors += test_errors;
    $display("%s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "mismatch",
             test_errors);
    test_errors = 0;
  endtask

  task automatic reset_values();
    compare_flag("out_req", out_req, 1'b0);
    compare_flag("overflow", overflow, 1'b0);
    compare_flag("align_error", align_error, 1'b0);
    report_test("reset");
  endtask

  task automatic three_bit_word();
    logic [lw-1:0]         top;
    logic [lw-1:0]         mid;
    logic [lw-1:0]         bot;
    dts_pkg::sample_word_t got;
    logic                  mode;
    int                    lat;
    top = rand_lane();
    mid = rand_lane();
    bot = rand_lane();
    send_beats(top, mid, bot, 1'b1, 4);
    lat = 1;  // one cycle already gone since the fourth beat
    while (!out_req && lat < 10) begin
      tick();
      lat++;
    end
    compare_count("req latency", lat, 3);
    host_take(2, got, mode);
    compare_word("out_data", got, expected_word(1'b1, top, mid, bot));
    compare_flag("out_three_bit", mode, 1'b1);
    report_test("three-bit word");
  endtask

  task automatic eight_bit_word();
    logic [lw-1:0]         top;
    logic [lw-1:0]         mid;
    logic [lw-1:0]         bot;
    dts_pkg::sample_word_t got;
    logic                  mode;
    top = rand_lane();
    mid = rand_lane();
    bot = rand_lane();
    send_beats(top, mid, bot, 1'b0, 4);
    host_take(0, got, mode);
    compare_word("out_data", got, expected_word(1'b0, top, mid, bot));
    compare_flag("out_three_bit", mode, 1'b0);
    report_test("eight-bit word");
  endtask

  task automatic realignment();
    logic [lw-1:0]         top;
    logic [lw-1:0]         mid;
    logic [lw-1:0]         bot;
    dts_pkg::sample_word_t got;
    logic                  mode;
    compare_flag("align_error", align_error, 1'b0);
    send_beats(rand_lane(), rand_lane(), rand_lane(), 1'b1, 2);  // partial, lost
    top = rand_lane();
    mid = rand_lane();
    bot = rand_lane();
    send_beats(top, mid, bot, 1'b0, 4);
    compare_flag("align_error", align_error, 1'b1);
    host_take(1, got, mode);
    compare_word("out_data", got, expected_word(1'b0, top, mid, bot));
    compare_flag("out_three_bit", mode, 1'b0);
    expect_quiet(20);  // partial word never reaches the host
    report_test("realignment");
  endtask

  task automatic overflow_and_order();
    dts_pkg::sample_word_t exp_q[$];
    logic                  mode_q[$];
    logic [lw-1:0]         top;
    logic [lw-1:0]         mid;
    logic [lw-1:0]         bot;
    logic                  mode;
    dts_pkg::sample_word_t got;
    logic                  got_mode;
    compare_flag("overflow", overflow, 1'b0);
    for (int k = 0; k < 6; k++) begin
      top  = rand_lane();
      mid  = rand_lane();
      bot  = rand_lane();
      mode = (k % 2 == 0);  // alternate formats
      exp_q.push_back(expected_word(mode, top, mid, bot));
      mode_q.push_back(mode);
      send_beats(top, mid, bot, mode, 4);
    end
    repeat (2) tick();  // last write lands
    compare_flag("overflow", overflow, 1'b1);
    // one in the port register plus four in the FIFO, the sixth is gone
    for (int k = 0; k < 5; k++) begin
      host_take(1, got, got_mode);
      compare_word("out_data", got, exp_q[k]);
      compare_flag("out_three_bit", got_mode, mode_q[k]);
    end
    expect_quiet(20);
    report_test("overflow and order");
  endtask

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the DUT stopped responding", max_cycles);
    $display("tests failed");
    $finish;
  end

  initial begin
    void'($urandom(32'he6b7));
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    arst_n       = 1'b0;
    lane_beat    = '0;
    beat_valid   = 1'b0;
    frame_start  = 1'b0;
    is_three_bit = 1'b0;
    out_ack      = 1'b0;
    repeat (5) @(posedge clk);
    #drive_delay;
    arst_n = 1'b1;
    tick();
    reset_values();
    three_bit_word();
    eight_bit_word();
    realignment();
    overflow_and_order();
    errors += dts_top_i.port_i.host_port_chk.fail_count;  // assertion hits
    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/dts_tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

// four-phase rules on the host side of dts_host_port
module dts_tb_checker (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  out_req,
  input logic                  out_ack,
  input dts_pkg::sample_word_t out_data,
  input logic                  out_three_bit
);

  int unsigned fail_count = 0;  // read by the testbench at the end

  // word frozen while req is up
  property data_held;
    @(posedge clk) disable iff (!arst_n)
      out_req && $past(out_req) |-> $stable(out_data) && $stable(out_three_bit);
  endproperty

  // no new req before the host has released ack
  property no_req_under_ack;
    @(posedge clk) disable iff (!arst_n)
      !out_req && out_ack |=> !out_req;
  endproperty

  // req drops only as an answer to ack
  property req_falls_on_ack;
    @(posedge clk) disable iff (!arst_n)
      $fell(out_req) |-> $past(out_ack);
  endproperty

  assert property (data_held) else begin
    $error("out_data or out_three_bit changed while out_req was high");
    fail_count++;
  end

  assert property (no_req_under_ack) else begin
    $error("out_req rose while out_ack was still high");
    fail_count++;
  end

  assert property (req_falls_on_ack) else begin
    $error("out_req fell without out_ack high");
    fail_count++;
  end

endmodule

bind dts_host_port dts_tb_checker host_port_chk (
  .clk           (clk),
  .arst_n        (arst_n),
  .out_req       (out_req),
  .out_ack       (out_ack),
  .out_data      (out_data),
  .out_three_bit (out_three_bit)
);

`default_nettype wire
